//--- sim.f
+incdir+include
verilog/posit_pkg.sv
verilog/posit_input_stage.sv
verilog/posit_noncomp.sv
verilog/posit_noncomp_slice.sv
verilog/posit_unit_top.sv
tests/tb_posit_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the posit unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_posit_unit \
  -f sim.f \
  --Mdir obj_dir -o tb_posit_unit

./obj_dir/tb_posit_unit | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

//--- include/posit_ref_model.svh
// Reference model for expected posit lane and word results of the noncomp unit
`ifndef POSIT_REF_MODEL_SVH
`define POSIT_REF_MODEL_SVH

// One lane, straight from the result rules
function automatic void ref_lane(input posit_pkg::posit_t a, input posit_pkg::posit_t b,
                                 input posit_pkg::operation_e op, input logic op_mod,
                                 input posit_pkg::cmp_mode_e mode,
                                 output posit_pkg::posit_t res, output logic nv,
                                 output posit_pkg::classmask_e cls);
  logic a_nar, b_nar, lt, hit;
  a_nar = (a == posit_pkg::NAR_PATTERN);
  b_nar = (b == posit_pkg::NAR_PATTERN);
  lt    = ($signed(a) < $signed(b));
  nv    = 1'b0;
  if (a == '0) cls = posit_pkg::ZERO;
  else if (a_nar) cls = posit_pkg::NAR;
  else if (a[7]) cls = posit_pkg::NEG;
  else cls = posit_pkg::POS;
  case (op)
    posit_pkg::MINMAX: begin
      nv = a_nar | b_nar;
      if (a_nar) res = b;  // Both NaR also lands here
      else if (b_nar) res = a;
      else res = (lt ^ op_mod) ? a : b;
    end
    posit_pkg::SGNJ: begin
      res = (a == '0 || a_nar || a[7] == (b[7] ^ op_mod)) ? a : -a;
    end
    posit_pkg::CMP: begin
      nv  = a_nar | b_nar;
      hit = (mode == posit_pkg::EQ && a == b) || (mode == posit_pkg::LT && lt) ||
            (mode == posit_pkg::LE && (lt || a == b));
      res = (hit && !nv) ? 8'h01 : 8'h00;
    end
    default: res = {4'b0, cls};
  endcase
endfunction

// Whole word with sign-extension, class packing and masked status
function automatic posit_pkg::posit_resp_t ref_word(input posit_pkg::posit_req_t req);
  posit_pkg::posit_resp_t resp;
  posit_pkg::posit_t      res;
  posit_pkg::classmask_e  cls;
  logic                   nv, is_class;
  resp     = '0;
  is_class = (req.op == posit_pkg::CLASSIFY);
  for (int i = 0; i < posit_pkg::NUM_LANES; i++) begin
    if (i == 0 || req.vectorial) begin
      ref_lane(req.operands[0][i*8 +: 8], req.operands[1][i*8 +: 8], req.op, req.op_mod,
               req.cmp_mode, res, nv, cls);
      if (i == 0) resp.extension_bit = res[7];
      if (is_class) resp.result[i*4 +: 4] = cls;
      else resp.result[i*8 +: 8] = res;
      if (nv && req.simd_mask[i]) resp.status.nv = 1'b1;
    end else if (!is_class) begin
      resp.result[i*8 +: 8] = {8{resp.extension_bit}};
    end
  end
  resp.tag = req.tag;
  return resp;
endfunction

`endif

//--- tests/tb_posit_unit.sv
// Testbench for the posit noncomp unit with directed, random and back-pressure traffic
`timescale 1ns/1ps
`default_nettype none

module tb_posit_unit
  import posit_pkg::*;
();

  `include "posit_ref_model.svh"

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned N_DIRECTED = 22;
  localparam int unsigned N_SCALAR   = 40;
  localparam int unsigned N_VECTOR   = 40;
  localparam int unsigned N_CLASS    = 16;
  localparam int unsigned N_STRESS   = 80;
  localparam int unsigned N_REQ      = N_DIRECTED + N_SCALAR + N_VECTOR + N_CLASS + N_STRESS;
  localparam int unsigned LATENCY    = 1 + NUM_PIPE_REGS;  // Skid stage plus lane pipe
  localparam logic [31:0] SEED       = 32'h18209756;

  logic        clk_i, arst_n_i;
  posit_req_t  req_i;
  logic        in_valid_i, in_ready_o;
  posit_resp_t resp_o;
  logic        out_valid_o, out_ready_i, busy_o;

  int unsigned errors, checks, sent, received, cycle, acc_cycle;
  logic [31:0] stim_lfsr, ready_lfsr;
  logic        ready_b0, ready_b1;
  logic        stress, check_latency;
  tag_t        next_tag;
  posit_resp_t exp_resp;
  posit_resp_t exp_q[$];
  int unsigned accept_q[$];

  posit_unit_top i_posit_unit_top (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .resp_o      ( resp_o      ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------
  // Random sources
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
  endtask

  // Corner values mixed with plain random ones
  task automatic draw_lane(output posit_t p);
    logic [31:0] sel, val;
    draw_bits(3, sel);
    draw_bits(8, val);
    case (sel[2:0])
      3'd0:    p = 8'h00;
      3'd1:    p = NAR_PATTERN;
      3'd2:    p = 8'h01;
      3'd3:    p = 8'hFF;
      3'd4:    p = val[0] ? 8'h7F : 8'h81;  // Extremes
      default: p = val[7:0];
    endcase
  endtask

  task automatic build_req(input operation_e op, input logic vec, output posit_req_t r);
    logic [31:0] bits;
    posit_t      p;
    r = '0;
    for (int k = 0; k < int'(NUM_OPERANDS); k++) begin
      for (int l = 0; l < int'(NUM_LANES); l++) begin
        draw_lane(p);
        r.operands[k][l*8 +: 8] = p;
      end
    end
    draw_bits(7, bits);
    r.op        = op;
    r.op_mod    = bits[0];
    r.cmp_mode  = (bits[2:1] == 2'd3) ? EQ : cmp_mode_e'(bits[2:1]);
    r.simd_mask = bits[6:3];
    r.vectorial = vec;
  endtask

  // ------------------------------
  // Driver
  // ------------------------------
  task automatic send(input posit_req_t r);
    r.tag = next_tag;
    next_tag++;
    req_i      <= r;
    in_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    sent++;
  endtask

  task automatic send_scalar(input operation_e op, input logic op_mod, input cmp_mode_e mode,
                             input posit_t a, input posit_t b);
    posit_req_t r;
    r             = '0;
    r.operands[0] = {24'hA5C3E1, a};  // Upper lanes must be ignored
    r.operands[1] = {24'h5A3C1E, b};
    r.op          = op;
    r.op_mod      = op_mod;
    r.cmp_mode    = mode;
    r.simd_mask   = 4'b0001;
    send(r);
  endtask

  task automatic drain();
    in_valid_i <= 1'b0;
    while (received != sent) @(posedge clk_i);
  endtask

  always @(posedge clk_i) begin : ready_driver
    if (stress) begin
      ready_lfsr = lfsr_step(ready_lfsr);
      ready_b0   = ready_lfsr[0];
      ready_lfsr = lfsr_step(ready_lfsr);
      ready_b1   = ready_lfsr[0];
      out_ready_i <= ready_b0 | ready_b1;  // High about three cycles in four
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  always @(posedge clk_i) begin : monitor
    if (arst_n_i) begin
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(ref_word(req_i));
        accept_q.push_back(cycle);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Response with tag %h arrived with no request pending", resp_o.tag);
          errors++;
        end else begin
          exp_resp  = exp_q.pop_front();
          acc_cycle = accept_q.pop_front();
          received++;
          check_field("resp_o.tag", 32'(exp_resp.tag), 32'(resp_o.tag));
          check_field("resp_o.result", exp_resp.result, resp_o.result);
          check_field("resp_o.status", 32'(exp_resp.status), 32'(resp_o.status));
          check_field("resp_o.extension_bit", 32'(exp_resp.extension_bit),
                      32'(resp_o.extension_bit));
          if (check_latency) check_field("latency", LATENCY, cycle - acc_cycle);
        end
      end
    end
    cycle++;
  end

  // Held result stays put until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(resp_o))
  else begin
    $display("Response changed or dropped while the output was stalled");
    errors++;
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) out_valid_o |-> busy_o)
  else begin
    $display("Result valid while the unit reports not busy");
    errors++;
  end

  // Without back-pressure the input never stalls
  assert property (@(posedge clk_i) disable iff (!arst_n_i) check_latency |-> in_ready_o)
  else begin
    $display("Input ready dropped although the output was never stalled");
    errors++;
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : main
    posit_req_t  r;
    logic [31:0] bits;
    stim_lfsr     = SEED;
    ready_lfsr    = ~SEED;
    arst_n_i      = 1'b0;
    req_i         = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    stress        = 1'b0;
    check_latency = 1'b1;
    next_tag      = '0;
    errors        = 0;
    checks        = 0;
    sent          = 0;
    received      = 0;
    cycle         = 0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_field("out_valid_o", 32'd0, 32'(out_valid_o));
    check_field("busy_o", 32'd0, 32'(busy_o));
    check_field("in_ready_o", 32'd1, 32'(in_ready_o));

    // MINMAX, NaR gives way
    send_scalar(MINMAX, 1'b0, EQ, 8'h80, 8'h80);
    send_scalar(MINMAX, 1'b0, EQ, 8'h80, 8'h05);
    send_scalar(MINMAX, 1'b1, EQ, 8'h05, 8'h80);
    send_scalar(MINMAX, 1'b0, EQ, 8'hFF, 8'h01);
    send_scalar(MINMAX, 1'b1, EQ, 8'hFF, 8'h01);
    send_scalar(MINMAX, 1'b1, EQ, 8'h7F, 8'h81);
    // Sign injection, zero and NaR pass
    send_scalar(SGNJ, 1'b0, EQ, 8'h00, 8'h80);
    send_scalar(SGNJ, 1'b0, EQ, 8'h80, 8'h01);
    send_scalar(SGNJ, 1'b0, EQ, 8'h05, 8'hFF);
    send_scalar(SGNJ, 1'b0, EQ, 8'hFB, 8'h01);
    send_scalar(SGNJ, 1'b1, EQ, 8'h05, 8'hFF);
    send_scalar(SGNJ, 1'b1, EQ, 8'h7F, 8'h7F);
    send_scalar(CMP, 1'b0, EQ, 8'h80, 8'h80);
    send_scalar(CMP, 1'b0, LT, 8'h80, 8'h01);
    send_scalar(CMP, 1'b0, LE, 8'h01, 8'h80);
    send_scalar(CMP, 1'b0, EQ, 8'h03, 8'h03);
    send_scalar(CMP, 1'b0, LT, 8'hFF, 8'h01);
    send_scalar(CMP, 1'b0, LE, 8'h7F, 8'h81);
    send_scalar(CLASSIFY, 1'b0, EQ, 8'h00, 8'h00);
    send_scalar(CLASSIFY, 1'b0, EQ, 8'h80, 8'h00);
    send_scalar(CLASSIFY, 1'b0, EQ, 8'h05, 8'h00);
    send_scalar(CLASSIFY, 1'b0, EQ, 8'hF0, 8'h00);

    repeat (N_SCALAR) begin
      draw_bits(2, bits);
      build_req(operation_e'(bits[1:0] % 2'd3), 1'b0, r);
      send(r);
    end
    repeat (N_VECTOR) begin
      draw_bits(2, bits);
      build_req(operation_e'(bits[1:0]), 1'b1, r);
      send(r);
    end
    repeat (N_CLASS) begin
      draw_bits(1, bits);
      build_req(CLASSIFY, bits[0], r);
      send(r);
    end
    drain();

    // Random back-pressure with gaps on the input
    stress        <= 1'b1;
    check_latency <= 1'b0;
    repeat (N_STRESS) begin
      draw_bits(4, bits);
      build_req(operation_e'(bits[1:0]), bits[2], r);
      send(r);
      if (bits[3]) begin
        in_valid_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    drain();

    $display("Checks: %0d, errors: %0d, requests sent: %0d, responses: %0d",
             checks, errors, sent, received);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (N_REQ * 20 + 200) @(posedge clk_i);
    $display("Timeout, only %0d of %0d responses arrived", received, N_REQ);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/posit_unit_top.sv
// Posit noncomp unit top: input skid stage feeding the SIMD lane slice
`timescale 1ns/1ps
`default_nettype none

module posit_unit_top
  import posit_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  posit_req_t  req_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output posit_resp_t resp_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output logic        busy_o
);

  // Registered request into the slice
  posit_req_t stage_req;
  logic       stage_valid, stage_ready;

  posit_input_stage i_input_stage (
    .clk_i,
    .arst_n_i,
    .in_req_i    ( req_i       ),
    .in_valid_i,
    .in_ready_o,
    .out_req_o   ( stage_req   ),
    .out_valid_o ( stage_valid ),
    .out_ready_i ( stage_ready )
  );

  posit_noncomp_slice i_slice (
    .clk_i,
    .arst_n_i,
    .req_i       ( stage_req   ),
    .in_valid_i  ( stage_valid ),
    .in_ready_o  ( stage_ready ),
    .resp_o,
    .out_valid_o,
    .out_ready_i,
    .busy_o
  );

endmodule

`default_nettype wire

//--- verilog/posit_noncomp_slice.sv
// SIMD noncomp slice: fans a request over the posit lanes and merges results and status
`timescale 1ns/1ps
`default_nettype none

module posit_noncomp_slice
  import posit_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Request handshake
  input  posit_req_t  req_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  // Response handshake
  output posit_resp_t resp_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output logic        busy_o
);

  logic [NUM_LANES-1:0] lane_in_ready, lane_out_valid;
  logic [NUM_LANES-1:0] lane_ext_bit;   // Lane 0 drives the extension
  logic [NUM_LANES-1:0] lane_masks;
  logic [NUM_LANES-1:0] lane_vectorial;
  logic [NUM_LANES-1:0] lane_is_class;
  logic [NUM_LANES-1:0] lane_busy;

  status_t    [NUM_LANES-1:0] lane_status;
  classmask_e [NUM_LANES-1:0] lane_class_mask;
  tag_t       [NUM_LANES-1:0] lane_tags;

  word_t   slice_result;
  word_t   vec_class_result, class_result;
  status_t collapsed_status;
  logic    result_is_vector, result_is_class;

  // ------------------------------
  // Input side
  // ------------------------------
  assign in_ready_o = lane_in_ready[0]; // Lanes move in lockstep

  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    posit_t [NUM_OPERANDS-1:0] local_operands;
    posit_t                    op_result;
    status_t                   op_status;
    logic                      in_valid, out_valid, out_ready;

    // Upper lanes take vector requests only together with lane 0
    assign in_valid = in_valid_i & ((lane == 0) | (req_i.vectorial & lane_in_ready[0]));

    always_comb begin : slice_operands
      for (int i = 0; i < int'(NUM_OPERANDS); i++) begin
        local_operands[i] = req_i.operands[i][lane*LANE_WIDTH +: LANE_WIDTH];
      end
    end

    posit_noncomp #(
      .NumPipeRegs ( NUM_PIPE_REGS )
    ) i_noncomp (
      .clk_i,
      .arst_n_i,
      .operands_i      ( local_operands        ),
      .op_i            ( req_i.op              ),
      .op_mod_i        ( req_i.op_mod          ),
      .cmp_mode_i      ( req_i.cmp_mode        ),
      .tag_i           ( req_i.tag             ),
      .mask_i          ( req_i.simd_mask[lane] ),
      .vectorial_i     ( req_i.vectorial       ), // Travels with the data
      .in_valid_i      ( in_valid              ),
      .in_ready_o      ( lane_in_ready[lane]   ),
      .result_o        ( op_result             ),
      .status_o        ( op_status             ),
      .class_mask_o    ( lane_class_mask[lane] ),
      .is_class_o      ( lane_is_class[lane]   ),
      .extension_bit_o ( lane_ext_bit[lane]    ),
      .tag_o           ( lane_tags[lane]       ),
      .mask_o          ( lane_masks[lane]      ),
      .vectorial_o     ( lane_vectorial[lane]  ),
      .out_valid_o     ( out_valid             ),
      .out_ready_i     ( out_ready             ),
      .busy_o          ( lane_busy[lane]       )
    );

    // Upper lanes hand over only when the head result is a vector
    assign out_ready            = out_ready_i & ((lane == 0) | result_is_vector);
    assign lane_out_valid[lane] = out_valid & ((lane == 0) | result_is_vector);

    // Unused lanes carry the sign-extension of lane 0
    assign slice_result[lane*LANE_WIDTH +: LANE_WIDTH] =
      lane_out_valid[lane] ? op_result : {LANE_WIDTH{lane_ext_bit[0]}};
    assign lane_status[lane] = lane_out_valid[lane] ? op_status : '0;

    // Vector class field of this lane
    assign vec_class_result[lane*$bits(classmask_e) +: $bits(classmask_e)] =
      lane_class_mask[lane];
  end

  // ------------------------------
  // Output side
  // ------------------------------
  assign result_is_vector = lane_vectorial[0];
  assign result_is_class  = lane_is_class[0];

  // Zero padding above the packed classes
  assign vec_class_result[DATA_WIDTH-1:NUM_LANES*$bits(classmask_e)] = '0;

  assign class_result = result_is_vector ? vec_class_result : word_t'(lane_class_mask[0]);

  // Masked status collapse
  always_comb begin : collapse_status
    collapsed_status = '0;
    for (int i = 0; i < int'(NUM_LANES); i++) begin
      collapsed_status |= lane_status[i] & {$bits(status_t){lane_masks[i]}};
    end
  end

  assign resp_o = '{
    result:        result_is_class ? class_result : slice_result,
    status:        collapsed_status,
    extension_bit: lane_ext_bit[0],
    tag:           lane_tags[0]
  };

  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

`default_nettype wire

//--- verilog/posit_noncomp.sv
// Posit lane: min/max, sign injection, compare and classify behind a valid/ready pipeline
`timescale 1ns/1ps
`default_nettype none

module posit_noncomp
  import posit_pkg::*;
#(
  parameter int unsigned NumPipeRegs = NUM_PIPE_REGS
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Request side
  input  posit_t [NUM_OPERANDS-1:0] operands_i,
  input  operation_e                op_i,
  input  logic                      op_mod_i,
  input  cmp_mode_e                 cmp_mode_i,
  input  tag_t                      tag_i,
  input  logic                      mask_i,
  input  logic                      vectorial_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  // Result side
  output posit_t                    result_o,
  output status_t                   status_o,
  output classmask_e                class_mask_o,
  output logic                      is_class_o,
  output logic                      extension_bit_o,
  output tag_t                      tag_o,
  output logic                      mask_o,
  output logic                      vectorial_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  // Everything that travels down the pipe together
  typedef struct packed {
    posit_t     result;
    status_t    status;
    classmask_e class_mask;
    logic       is_class;
    tag_t       tag;
    logic       mask;
    logic       vectorial;
  } lane_payload_t;

  posit_t        op_a, op_b;
  logic          a_nar, b_nar, a_zero;
  logic          a_lt_b, a_eq_b;
  logic          sgnj_sign;
  logic          cmp_true;
  posit_t        minmax_res, sgnj_res, cmp_res;
  classmask_e    class_a;
  lane_payload_t in_payload;

  // ------------------------------
  // Operations
  // ------------------------------
  assign op_a   = operands_i[0];
  assign op_b   = operands_i[1];
  assign a_nar  = (op_a == NAR_PATTERN);
  assign b_nar  = (op_b == NAR_PATTERN);
  assign a_zero = (op_a == '0);
  assign a_lt_b = ($signed(op_a) < $signed(op_b)); // Posits order like integers
  assign a_eq_b = (op_a == op_b);

  always_comb begin : minmax
    if (a_nar && b_nar) begin
      minmax_res = NAR_PATTERN;
    end else if (a_nar) begin
      minmax_res = op_b;             // NaR gives way
    end else if (b_nar) begin
      minmax_res = op_a;
    end else if (op_mod_i) begin
      minmax_res = a_lt_b ? op_b : op_a; // Max
    end else begin
      minmax_res = a_lt_b ? op_a : op_b; // Min
    end
  end

  // Negation is the two's complement for posits
  assign sgnj_sign = op_b[LANE_WIDTH-1] ^ op_mod_i;
  assign sgnj_res  = (a_zero || a_nar || (op_a[LANE_WIDTH-1] == sgnj_sign))
                   ? op_a : (~op_a + 1'b1);

  always_comb begin : compare
    case (cmp_mode_i)
      EQ:      cmp_true = a_eq_b;
      LT:      cmp_true = a_lt_b;
      LE:      cmp_true = a_lt_b | a_eq_b;
      default: cmp_true = 1'b0;
    endcase
  end

  assign cmp_res = (a_nar || b_nar) ? '0 : posit_t'(cmp_true);

  always_comb begin : classify
    if (a_zero) begin
      class_a = ZERO;
    end else if (a_nar) begin
      class_a = NAR;
    end else if (op_a[LANE_WIDTH-1]) begin
      class_a = NEG;
    end else begin
      class_a = POS;
    end
  end

  // Result select and sideband
  always_comb begin : select_result
    in_payload            = '0;
    in_payload.class_mask = class_a;
    in_payload.is_class   = (op_i == CLASSIFY);
    in_payload.tag        = tag_i;
    in_payload.mask       = mask_i;
    in_payload.vectorial  = vectorial_i;
    case (op_i)
      MINMAX: begin
        in_payload.result    = minmax_res;
        in_payload.status.nv = a_nar | b_nar;
      end
      SGNJ: in_payload.result = sgnj_res;
      CMP: begin
        in_payload.result    = cmp_res;
        in_payload.status.nv = a_nar | b_nar;
      end
      default: in_payload.result = posit_t'(class_a); // Class in low nibble
    endcase
  end

  // ------------------------------
  // Pipeline
  // ------------------------------
  lane_payload_t        stage_data  [NumPipeRegs+1];
  logic                 stage_valid [NumPipeRegs+1];
  logic [NumPipeRegs:0] stage_ready;

  // Index 0 is the unregistered input
  assign stage_data[0]            = in_payload;
  assign stage_valid[0]           = in_valid_i;
  assign in_ready_o               = stage_ready[0];
  assign stage_ready[NumPipeRegs] = out_ready_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe_regs
    // Load when empty or when the next stage takes our item
    assign stage_ready[i] = ~stage_valid[i+1] | stage_ready[i+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o |= stage_valid[i];
    end
  end

  // Outputs from the last stage
  assign result_o        = stage_data[NumPipeRegs].result;
  assign status_o        = stage_data[NumPipeRegs].status;
  assign class_mask_o    = stage_data[NumPipeRegs].class_mask;
  assign is_class_o      = stage_data[NumPipeRegs].is_class;
  assign extension_bit_o = stage_data[NumPipeRegs].result[LANE_WIDTH-1];
  assign tag_o           = stage_data[NumPipeRegs].tag;
  assign mask_o          = stage_data[NumPipeRegs].mask;
  assign vectorial_o     = stage_data[NumPipeRegs].vectorial;
  assign out_valid_o     = stage_valid[NumPipeRegs];

endmodule

`default_nettype wire

//--- verilog/posit_input_stage.sv
// Request skid buffer: two entries, registered ready, full throughput
`timescale 1ns/1ps
`default_nettype none

module posit_input_stage
  import posit_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Upstream
  input  posit_req_t in_req_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  // Downstream
  output posit_req_t out_req_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  posit_req_t main_q, spare_q;
  logic       main_valid_q, spare_valid_q;
  logic       in_fire;
  logic       main_load;

  // Ready straight from a flop
  assign in_ready_o = ~spare_valid_q;
  assign in_fire    = in_valid_i & in_ready_o;

  // Main register free or draining this cycle
  assign main_load = ~main_valid_q | out_ready_i;

  // ------------------------------
  // Occupancy
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid_q  <= spare_valid_q | in_fire;
        spare_valid_q <= 1'b0;  // Spare always drains first
      end else if (in_fire) begin
        spare_valid_q <= 1'b1;  // Catch the request that raced falling ready
      end
    end
  end

  // ------------------------------
  // Payload
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_q <= spare_valid_q ? spare_q : in_req_i;
    end
    if (!main_load && in_fire) begin
      spare_q <= in_req_i;
    end
  end

  assign out_req_o   = main_q;
  assign out_valid_o = main_valid_q;

endmodule

`default_nettype wire

//--- verilog/posit_pkg.sv
// Posit unit package: lane widths, operation encodings, status and request/response types
`default_nettype none

package posit_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned LANE_WIDTH    = 8;  // Posit size per lane
  localparam int unsigned NUM_LANES     = 4;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned NUM_OPERANDS  = 2;
  localparam int unsigned TAG_WIDTH     = 4;
  localparam int unsigned NUM_PIPE_REGS = 2;  // Default lane depth

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [LANE_WIDTH-1:0] posit_t;
  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [TAG_WIDTH-1:0]  tag_t;
  typedef logic [NUM_LANES-1:0]  lane_mask_t;

  // Not-a-Real, sign bit alone
  localparam posit_t NAR_PATTERN = {1'b1, {(LANE_WIDTH-1){1'b0}}};

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [1:0] {
    MINMAX,
    SGNJ,
    CMP,
    CLASSIFY
  } operation_e;

  typedef enum logic [1:0] {
    EQ,
    LT,
    LE
  } cmp_mode_e;

  // One-hot class, packed as is into classify results
  typedef enum logic [3:0] {
    ZERO = 4'b0001,
    NAR  = 4'b0010,
    POS  = 4'b0100,
    NEG  = 4'b1000
  } classmask_e;

  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // ------------------------------
  // Request and response
  // ------------------------------
  typedef struct packed {
    word_t [NUM_OPERANDS-1:0] operands;
    operation_e               op;
    logic                     op_mod;
    cmp_mode_e                cmp_mode;
    logic                     vectorial;
    tag_t                     tag;
    lane_mask_t               simd_mask;
  } posit_req_t;

  typedef struct packed {
    word_t   result;
    status_t status;
    logic    extension_bit;
    tag_t    tag;
  } posit_resp_t;

endpackage

`default_nettype wire
